//--- debug_bridge_consts.svh
`ifndef DEBUG_BRIDGE_CONSTS_SVH
`define DEBUG_BRIDGE_CONSTS_SVH

// clock cycles per bit on both serial lines
`define DBG_CLKS_PER_BAUD 33

// number of 16-bit words in the memory
`define DBG_MEM_DEPTH 256

// command and reply letters
`define DBG_ASCII_R 8'h52
`define DBG_ASCII_W 8'h57
`define DBG_ASCII_D 8'h44

// either line ending closes a command
`define DBG_ASCII_CR 8'h0D
`define DBG_ASCII_LF 8'h0A

// bounds of the two hex digit ranges
`define DBG_ASCII_0 8'h30
`define DBG_ASCII_9 8'h39
`define DBG_ASCII_A 8'h41
`define DBG_ASCII_F 8'h46

// D, four digits, CR, LF
`define DBG_REPLY_LEN 7

`endif

//--- debug_bridge_pkg.sv
`include "debug_bridge_consts.svh"

package debug_bridge_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [3:0] nibble_t;

    typedef enum logic [1:0] {PARSE_IDLE, PARSE_READ, PARSE_WRITE} parser_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_DATA, RX_STOP} rx_state_e;

    // only upper-case letters count as hex
    function automatic logic is_ascii_hex(input byte_t c);
        return ((c >= `DBG_ASCII_0) && (c <= `DBG_ASCII_9)) ||
               ((c >= `DBG_ASCII_A) && (c <= `DBG_ASCII_F));
    endfunction

    function automatic nibble_t from_ascii_hex(input byte_t c);
        byte_t v;
        if (c <= `DBG_ASCII_9) begin
            v = c - `DBG_ASCII_0;
        end else begin
            v = c - `DBG_ASCII_A + 8'd10;
        end
        return v[3:0];
    endfunction

    function automatic byte_t to_ascii_hex(input nibble_t n);
        if (n < 4'd10) begin
            return `DBG_ASCII_0 + {4'h0, n};
        end
        return `DBG_ASCII_A + {4'h0, n} - 8'd10;
    endfunction

endpackage

//--- uart_rx.sv
`timescale 1ns/1ps
`include "debug_bridge_consts.svh"

module uart_rx import debug_bridge_pkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  rx_i,
    output byte_t data_o,
    output logic  valid_o
);

    localparam int CPB = `DBG_CLKS_PER_BAUD;
    localparam int CNT_W = $clog2(CPB + CPB / 2);

    // from the start edge to the middle of bit 0
    localparam logic [CNT_W-1:0] FIRST_WAIT = CNT_W'(CPB + CPB / 2 - 1);
    localparam logic [CNT_W-1:0] BIT_WAIT = CNT_W'(CPB - 1);

    logic [1:0] sync_q;
    logic line_s;
    rx_state_e state_q;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0] bit_cnt;
    logic sample_s;

    // two-flop synchronizer for a line that idles high
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rx_i};
        end
    end

    assign line_s = sync_q[1];
    assign sample_s = (state_q == RX_DATA) && (baud_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (!line_s) begin
                        state_q <= RX_DATA;
                        baud_cnt <= FIRST_WAIT;
                        bit_cnt <= '0;
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == '0) begin
                        baud_cnt <= BIT_WAIT;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                RX_STOP: begin
                    // the stop bit level is not checked
                    if (baud_cnt == '0) begin
                        valid_o <= 1'b1;
                        state_q <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first so bits shift in from the top
    always_ff @(posedge clk) begin
        if (sample_s) begin
            data_o <= {line_s, data_o[7:1]};
        end
    end

endmodule

//--- cmd_parser.sv
`timescale 1ns/1ps
`include "debug_bridge_consts.svh"

module cmd_parser import debug_bridge_pkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  byte_t data_i,
    input  logic  valid_i,
    output addr_t addr_o,
    output word_t data_o,
    output logic  write_o,
    output logic  valid_o
);

    parser_state_e state_q;
    logic [3:0] digit_cnt;
    logic [31:0] digit_buf;
    logic is_hex_s;
    logic is_eol_s;
    logic emit_rd_s;
    logic emit_wr_s;

    assign is_hex_s = is_ascii_hex(data_i);
    assign is_eol_s = (data_i == `DBG_ASCII_CR) || (data_i == `DBG_ASCII_LF);

    // terminator seen right after the last digit
    assign emit_rd_s = valid_i && (state_q == PARSE_READ) && (digit_cnt == 4'd4) && is_eol_s;
    assign emit_wr_s = valid_i && (state_q == PARSE_WRITE) && (digit_cnt == 4'd8) && is_eol_s;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= PARSE_IDLE;
            digit_cnt <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= emit_rd_s || emit_wr_s;
            if (valid_i) begin
                case (state_q)
                    PARSE_IDLE: begin
                        digit_cnt <= '0;
                        if (data_i == `DBG_ASCII_R) begin
                            state_q <= PARSE_READ;
                        end else if (data_i == `DBG_ASCII_W) begin
                            state_q <= PARSE_WRITE;
                        end
                    end
                    PARSE_READ: begin
                        if (digit_cnt == 4'd4) begin
                            state_q <= PARSE_IDLE;
                        end else if (is_hex_s) begin
                            digit_cnt <= digit_cnt + 4'd1;
                        end else begin
                            state_q <= PARSE_IDLE;
                        end
                    end
                    PARSE_WRITE: begin
                        if (digit_cnt == 4'd8) begin
                            state_q <= PARSE_IDLE;
                        end else if (is_hex_s) begin
                            digit_cnt <= digit_cnt + 4'd1;
                        end else begin
                            state_q <= PARSE_IDLE;
                        end
                    end
                    default: state_q <= PARSE_IDLE;
                endcase
            end
        end
    end

    // digits shift in most significant first
    always_ff @(posedge clk) begin
        if (valid_i && (state_q != PARSE_IDLE) && is_hex_s) begin
            digit_buf <= {digit_buf[27:0], from_ascii_hex(data_i)};
        end
    end

    // a read keeps its address in the low four digits
    always_ff @(posedge clk) begin
        if (emit_rd_s) begin
            addr_o <= digit_buf[15:0];
            data_o <= '0;
            write_o <= 1'b0;
        end else if (emit_wr_s) begin
            addr_o <= digit_buf[31:16];
            data_o <= digit_buf[15:0];
            write_o <= 1'b1;
        end
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps
`include "debug_bridge_consts.svh"

module mem_stage import debug_bridge_pkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  addr_t addr_i,
    input  word_t data_i,
    input  logic  write_i,
    input  logic  valid_i,
    output word_t rd_data_o,
    output logic  rd_valid_o
);

    localparam int IDX_W = $clog2(`DBG_MEM_DEPTH);

    word_t mem [`DBG_MEM_DEPTH];
    logic [IDX_W-1:0] idx_q;
    word_t ram_q;
    word_t out_q;
    logic in_range_s;
    logic [2:0] valid_pipe;
    logic [2:0] write_pipe;
    logic [2:0] range_pipe;

    assign in_range_s = (addr_i < `DBG_MEM_DEPTH);

    // writes land at once while reads go through idx_q
    always_ff @(posedge clk) begin
        if (valid_i && write_i && in_range_s) begin
            mem[addr_i[IDX_W-1:0]] <= data_i;
        end
        idx_q <= addr_i[IDX_W-1:0];
        ram_q <= mem[idx_q];
        out_q <= ram_q;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[1:0], valid_i};
        end
    end

    always_ff @(posedge clk) begin
        write_pipe <= {write_pipe[1:0], write_i};
        range_pipe <= {range_pipe[1:0], in_range_s};
    end

    // out of range reads return zero
    assign rd_data_o = range_pipe[2] ? out_q : '0;
    assign rd_valid_o = valid_pipe[2] && !write_pipe[2];

endmodule

//--- resp_formatter.sv
`timescale 1ns/1ps
`include "debug_bridge_consts.svh"

module resp_formatter import debug_bridge_pkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  word_t data_i,
    input  logic  valid_i,
    output byte_t byte_o,
    output logic  start_o,
    input  logic  done_i
);

    localparam logic [2:0] LAST_IDX = 3'(`DBG_REPLY_LEN - 1);

    logic busy_q;
    logic [2:0] idx_q;
    word_t word_q;
    logic last_acc_s;
    logic load_s;

    assign last_acc_s = busy_q && done_i && (idx_q == LAST_IDX);

    // a new word is taken when idle or as the LF goes out
    assign load_s = valid_i && (!busy_q || last_acc_s);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            idx_q <= '0;
        end else if (!busy_q) begin
            idx_q <= '0;
            if (valid_i) begin
                busy_q <= 1'b1;
            end
        end else if (done_i) begin
            if (idx_q == LAST_IDX) begin
                idx_q <= '0;
                busy_q <= valid_i;
            end else begin
                idx_q <= idx_q + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_s) begin
            word_q <= data_i;
        end
    end

    assign start_o = busy_q;

    // hex digits go out most significant first
    always_comb begin
        case (idx_q)
            3'd0: byte_o = `DBG_ASCII_D;
            3'd1: byte_o = to_ascii_hex(word_q[15:12]);
            3'd2: byte_o = to_ascii_hex(word_q[11:8]);
            3'd3: byte_o = to_ascii_hex(word_q[7:4]);
            3'd4: byte_o = to_ascii_hex(word_q[3:0]);
            3'd5: byte_o = `DBG_ASCII_CR;
            default: byte_o = `DBG_ASCII_LF;
        endcase
    end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps
`include "debug_bridge_consts.svh"

module uart_tx import debug_bridge_pkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  byte_t data_i,
    input  logic  start_i,
    output logic  done_o,
    output logic  tx_o
);

    localparam int CPB = `DBG_CLKS_PER_BAUD;
    localparam int BAUD_W = $clog2(CPB);
    localparam logic [BAUD_W-1:0] BAUD_RELOAD = BAUD_W'(CPB - 1);

    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0] bit_cnt;
    logic [8:0] shift_q;
    logic accept_s;
    logic next_bit_s;

    // byte handshake
    assign accept_s = start_i && done_o;
    assign next_bit_s = !done_o && (baud_cnt == '0) && (bit_cnt != 4'd9);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            done_o <= 1'b1;
            tx_o <= 1'b1;
            baud_cnt <= '0;
            bit_cnt <= '0;
        end else if (accept_s) begin
            // start bit goes out right away
            baud_cnt <= BAUD_RELOAD;
            bit_cnt <= '0;
            done_o <= 1'b0;
            tx_o <= 1'b0;
        end else if (!done_o) begin
            // done rises for the last cycle of the stop bit
            // so a waiting byte follows with no idle gap
            done_o <= (baud_cnt == BAUD_W'(1)) && (bit_cnt == 4'd9);
            if (baud_cnt == '0) begin
                baud_cnt <= BAUD_RELOAD;
            end else begin
                baud_cnt <= baud_cnt - 1'b1;
            end
            if (next_bit_s) begin
                tx_o <= shift_q[0];
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // eight data bits then the stop bit
    always_ff @(posedge clk) begin
        if (accept_s) begin
            shift_q <= {1'b1, data_i};
        end else if (next_bit_s) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

endmodule

//--- debug_bridge_top.sv
`timescale 1ns/1ps

module debug_bridge_top import debug_bridge_pkg::*; (
    input  logic clk,
    input  logic rst_i,
    input  logic rx_i,
    output logic tx_o
);

    byte_t rx_byte;
    logic rx_valid;

    addr_t cmd_addr;
    word_t cmd_data;
    logic cmd_write;
    logic cmd_valid;

    word_t rd_data;
    logic rd_valid;

    byte_t tx_byte;
    logic tx_start;
    logic tx_done;

    uart_rx urx0 (
        .clk     (clk),
        .rst_i   (rst_i),
        .rx_i    (rx_i),
        .data_o  (rx_byte),
        .valid_o (rx_valid)
    );

    cmd_parser parser0 (
        .clk     (clk),
        .rst_i   (rst_i),
        .data_i  (rx_byte),
        .valid_i (rx_valid),
        .addr_o  (cmd_addr),
        .data_o  (cmd_data),
        .write_o (cmd_write),
        .valid_o (cmd_valid)
    );

    mem_stage mem0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .addr_i     (cmd_addr),
        .data_i     (cmd_data),
        .write_i    (cmd_write),
        .valid_i    (cmd_valid),
        .rd_data_o  (rd_data),
        .rd_valid_o (rd_valid)
    );

    // reply path back to the host
    resp_formatter fmt0 (
        .clk     (clk),
        .rst_i   (rst_i),
        .data_i  (rd_data),
        .valid_i (rd_valid),
        .byte_o  (tx_byte),
        .start_o (tx_start),
        .done_i  (tx_done)
    );

    uart_tx utx0 (
        .clk     (clk),
        .rst_i   (rst_i),
        .data_i  (tx_byte),
        .start_i (tx_start),
        .done_o  (tx_done),
        .tx_o    (tx_o)
    );

endmodule

//--- tb_serial_tasks.svh
`ifndef TB_SERIAL_TASKS_SVH
`define TB_SERIAL_TASKS_SVH

    // compare and stop at the first mismatch
    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "first mismatch");
        end
    endtask

    // one 8N1 frame with the start bit first and data lsb first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_i <= frame[i];
            repeat (CPB - 1) @(posedge clk);
        end
    endtask

    task automatic send_string(input string s);
        int k;
        for (k = 0; k < s.len(); k++) begin
            send_byte(s[k]);
        end
    endtask

    // tx_o moves on rising edges and is sampled on falling ones
    task automatic receive_byte(output logic [7:0] b);
        int i;
        @(negedge clk);
        while (tx_o !== 1'b0) begin
            @(negedge clk);
        end
        // middle of the start bit
        repeat (CPB / 2) @(negedge clk);
        check_value("tx_o start bit", tx_o, 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (CPB) @(negedge clk);
            b[i] = tx_o;
        end
        repeat (CPB) @(negedge clk);
        check_value("tx_o stop bit", tx_o, 1'b1);
    endtask

    task automatic receive_reply(input string exp_str);
        logic [7:0] got;
        int n;
        for (n = 0; n < `DBG_REPLY_LEN; n++) begin
            receive_byte(got);
            check_value($sformatf("tx_o reply byte %0d", n), got, exp_str[n]);
        end
    endtask

    // no reply may start within fourteen bit times
    task automatic expect_quiet();
        int i;
        for (i = 0; i < 14 * CPB; i++) begin
            @(negedge clk);
            check_value("tx_o idle", tx_o, 1'b1);
        end
    endtask

`endif

//--- tb_debug_bridge.sv
`timescale 1ns/1ps
`include "debug_bridge_consts.svh"

module tb_debug_bridge;

    localparam int CPB = `DBG_CLKS_PER_BAUD;
    // room for about 20 entries of up to 16 bytes at 330 cycles each
    localparam int MAX_CYCLES = 120000;

    logic clk;
    logic rst_i;
    logic rx_i;
    logic tx_o;
    int cycle_cnt;
    int seed_ret;

    // stimulus table of command, reply flag and expected word
    string cmd_tab[$];
    bit reply_tab[$];
    logic [15:0] exp_tab[$];

    debug_bridge_top dut0 (
        .clk   (clk),
        .rst_i (rst_i),
        .rx_i  (rx_i),
        .tx_o  (tx_o)
    );

    `include "tb_serial_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // four upper-case hex digits with the most significant first
    function automatic string hex4(input logic [15:0] v);
        string s;
        logic [3:0] n;
        int k;
        s = "";
        for (k = 3; k >= 0; k--) begin
            n = v[k*4 +: 4];
            if (n < 4'd10) begin
                s = $sformatf("%s%c", s, 8'h30 + {4'h0, n});
            end else begin
                s = $sformatf("%s%c", s, 8'h41 + {4'h0, n} - 8'd10);
            end
        end
        return s;
    endfunction

    function automatic string wr_cmd(input logic [15:0] a, input logic [15:0] d,
                                     input string eol);
        return $sformatf("W%s%s%s", hex4(a), hex4(d), eol);
    endfunction

    function automatic string rd_cmd(input logic [15:0] a, input string eol);
        return $sformatf("R%s%s", hex4(a), eol);
    endfunction

    task automatic add_entry(input string cmd, input bit reply, input logic [15:0] exp);
        cmd_tab.push_back(cmd);
        reply_tab.push_back(reply);
        exp_tab.push_back(exp);
    endtask

    initial begin
        logic [15:0] w [0:6];
        logic [15:0] a1;
        logic [15:0] a2;
        int i;
        rst_i = 1'b1;
        rx_i = 1'b1;
        seed_ret = $urandom(32'h0b61_e0c1);
        for (i = 0; i < 7; i++) begin
            w[i] = 16'($urandom);
        end
        a1 = 16'($urandom % 16);
        a2 = 16'h0080 + 16'($urandom % 16);

        // the probed word starts out cleared by a write of zero
        add_entry(wr_cmd(16'h0040, 16'h0000, "\r"), 1'b0, 16'h0000);
        add_entry(wr_cmd(a1, w[0], "\r"), 1'b0, 16'h0000);
        add_entry(rd_cmd(a1, "\r"), 1'b1, w[0]);
        add_entry(wr_cmd(a2, w[1], "\n"), 1'b0, 16'h0000);
        add_entry(rd_cmd(a2, "\n"), 1'b1, w[1]);
        add_entry(wr_cmd(16'h00FF, w[2], "\r"), 1'b0, 16'h0000);
        add_entry(rd_cmd(16'h00FF, "\r"), 1'b1, w[2]);
        add_entry(rd_cmd(16'h0040, "\r"), 1'b1, 16'h0000);
        // malformed commands aimed at a1
        add_entry($sformatf("W%s12G4\r", hex4(a1)), 1'b0, 16'h0000);
        add_entry($sformatf("W%s1a34\r", hex4(a1)), 1'b0, 16'h0000);
        add_entry($sformatf("R%s5\r", hex4(a1)), 1'b0, 16'h0000);
        add_entry($sformatf("W%s12345\r", hex4(a1)), 1'b0, 16'h0000);
        add_entry($sformatf("X%s\r", hex4(a1)), 1'b0, 16'h0000);
        add_entry(rd_cmd(a1, "\r"), 1'b1, w[0]);
        // out of range write followed by reads of it and its alias
        add_entry(wr_cmd(16'h0100 | a1, w[3], "\r"), 1'b0, 16'h0000);
        add_entry(rd_cmd(16'h0100 | a1, "\r"), 1'b1, 16'h0000);
        add_entry(rd_cmd(a1, "\r"), 1'b1, w[0]);
        // three writes with no gap between them
        add_entry($sformatf("%s%s%s", wr_cmd(16'h0020, w[4], "\r"),
                            wr_cmd(16'h0021, w[5], "\n"), wr_cmd(16'h0022, w[6], "\r")),
                  1'b0, 16'h0000);
        add_entry(rd_cmd(16'h0020, "\r"), 1'b1, w[4]);
        add_entry(rd_cmd(16'h0021, "\r"), 1'b1, w[5]);
        add_entry(rd_cmd(16'h0022, "\r"), 1'b1, w[6]);

        repeat (2) @(posedge clk);
        rst_i <= 1'b0;

        for (i = 0; i < cmd_tab.size(); i++) begin
            if (reply_tab[i]) begin
                // the reply starts before the last stop bit ends
                fork
                    send_string(cmd_tab[i]);
                    receive_reply($sformatf("D%s\r\n", hex4(exp_tab[i])));
                join
            end else begin
                send_string(cmd_tab[i]);
                expect_quiet();
            end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- list.f
+incdir+.
debug_bridge_pkg.sv
uart_rx.sv
cmd_parser.sv
mem_stage.sv
resp_formatter.sv
uart_tx.sv
debug_bridge_top.sv
tb_debug_bridge.sv
